// File: verilog/lsu_pkg.sv
/* Widths and bit layouts of the load/store issue words. Fields are packed MSB first;
   the *_LSB and *_BIT constants give each field's position for packing and unpacking */
package lsu_pkg;

	// Register file geometry, one bank only
	localparam int XLEN = 64;
	localparam int PREG_NUM = 64;
	localparam int PREG_W = $clog2(PREG_NUM);

	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [PREG_W-1:0] preg_t;

	// Dispatched load: lb lh lw ld lbu lhu lwu, imm, rd0, rs1
	localparam int LU_INFO_W = 7 + XLEN + 2 * PREG_W;
	localparam int LU_RS1_LSB = 0;
	localparam int LU_RD0_LSB = LU_RS1_LSB + PREG_W;
	localparam int LU_IMM_LSB = LU_RD0_LSB + PREG_W;
	localparam int LU_LWU_BIT = LU_IMM_LSB + XLEN;
	localparam int LU_LHU_BIT = LU_LWU_BIT + 1;
	localparam int LU_LBU_BIT = LU_LWU_BIT + 2;
	localparam int LU_LD_BIT = LU_LWU_BIT + 3;
	localparam int LU_LW_BIT = LU_LWU_BIT + 4;
	localparam int LU_LH_BIT = LU_LWU_BIT + 5;
	localparam int LU_LB_BIT = LU_LWU_BIT + 6;

	typedef logic [LU_INFO_W-1:0] lu_issue_info_t;

	// Dispatched store: sb sh sw sd, imm, rs1, rs2
	localparam int SU_INFO_W = 4 + XLEN + 2 * PREG_W;
	localparam int SU_RS2_LSB = 0;
	localparam int SU_RS1_LSB = SU_RS2_LSB + PREG_W;
	localparam int SU_IMM_LSB = SU_RS1_LSB + PREG_W;
	localparam int SU_SD_BIT = SU_IMM_LSB + XLEN;
	localparam int SU_SW_BIT = SU_SD_BIT + 1;
	localparam int SU_SH_BIT = SU_SD_BIT + 2;
	localparam int SU_SB_BIT = SU_SD_BIT + 3;

	typedef logic [SU_INFO_W-1:0] su_issue_info_t;

	// Load execution word: fun_lb fun_lh fun_lw fun_ld, rd0, op1 address, is_usi
	localparam int LU_EXE_W = 4 + PREG_W + XLEN + 1;
	localparam int LU_EXE_USI_BIT = 0;
	localparam int LU_EXE_OP1_LSB = 1;
	localparam int LU_EXE_RD0_LSB = LU_EXE_OP1_LSB + XLEN;
	localparam int LU_EXE_LD_BIT = LU_EXE_RD0_LSB + PREG_W;
	localparam int LU_EXE_LW_BIT = LU_EXE_LD_BIT + 1;
	localparam int LU_EXE_LH_BIT = LU_EXE_LD_BIT + 2;
	localparam int LU_EXE_LB_BIT = LU_EXE_LD_BIT + 3;

	typedef logic [LU_EXE_W-1:0] lu_exeparam_t;

	// Store execution word: sb sh sw sd, op1 address, op2 data
	localparam int SU_EXE_W = 4 + 2 * XLEN;
	localparam int SU_EXE_OP2_LSB = 0;
	localparam int SU_EXE_OP1_LSB = SU_EXE_OP2_LSB + XLEN;
	localparam int SU_EXE_SD_BIT = SU_EXE_OP1_LSB + XLEN;
	localparam int SU_EXE_SW_BIT = SU_EXE_SD_BIT + 1;
	localparam int SU_EXE_SH_BIT = SU_EXE_SD_BIT + 2;
	localparam int SU_EXE_SB_BIT = SU_EXE_SD_BIT + 3;

	typedef logic [SU_EXE_W-1:0] su_exeparam_t;

endpackage

// File: verilog/lu_issue_if.sv
/* Load buffer to issue logic. A pop frees the named slot at the next clock edge;
   pop_index is only meaningful while pop is high */
interface lu_issue_if #(
	parameter int LU_DP = 8
);

	// One occupied bit and one dispatched load per slot
	logic [LU_DP-1:0] malloc;
	lsu_pkg::lu_issue_info_t info [LU_DP];

	// Single cycle strobe from issue
	logic pop;
	logic [$clog2(LU_DP)-1:0] pop_index;

	modport buffer (
		output malloc,
		output info,
		input  pop,
		input  pop_index
	);

	modport issue (
		input  malloc,
		input  info,
		output pop,
		output pop_index
	);

endinterface

// File: verilog/lu_issue_buffer.sv
/* Loads land in the lowest free slot. Ready ignores a same-cycle pop, so a full
   buffer stalls dispatch for one cycle after the first slot frees */
module lu_issue_buffer #(
	parameter int LU_DP = 8
) (
	input  logic CLK,
	input  logic reset,

	input  logic lu_dispatch_valid,
	input  lsu_pkg::lu_issue_info_t lu_dispatch_info,
	output logic lu_dispatch_ready,

	lu_issue_if.buffer lu_issue
);

	localparam int IDX_W = $clog2(LU_DP);

	logic [LU_DP-1:0] slot_valid;
	lsu_pkg::lu_issue_info_t slot_info [LU_DP];
	logic [IDX_W-1:0] free_index;
	logic dispatch_fire;

	// Lowest free slot
	// Scan from the top so the lowest index overwrites last
	always_comb begin
		free_index = '0;
		for (int i = LU_DP - 1; i >= 0; i--) begin
			if (!slot_valid[i]) begin
				free_index = IDX_W'(i);
			end
		end
	end

	// Full when every slot is occupied
	assign lu_dispatch_ready = ~&slot_valid;
	assign dispatch_fire = lu_dispatch_valid & lu_dispatch_ready;

	// Occupancy bits
	// A pop names an occupied slot, a dispatch a free one, so they never collide
	always_ff @(posedge CLK) begin
		if (reset) begin
			slot_valid <= '0;
		end else begin
			if (lu_issue.pop) begin
				slot_valid[lu_issue.pop_index] <= 1'b0;
			end
			if (dispatch_fire) begin
				slot_valid[free_index] <= 1'b1;
			end
		end
	end

	// Slot payload
	always_ff @(posedge CLK) begin
		if (dispatch_fire) begin
			slot_info[free_index] <= lu_dispatch_info;
		end
	end

	// Whole buffer exposed to the issue stage
	assign lu_issue.malloc = slot_valid;

	generate
		for (genvar g = 0; g < LU_DP; g++) begin : g_slot
			assign lu_issue.info[g] = slot_info[g];
		end
	endgenerate

endmodule

// File: verilog/su_issue_fifo.sv
/* In-order store queue, SU_DP a power of two. Head word is valid only while
   su_fifo_empty is low; a pop on an empty FIFO is ignored */
module su_issue_fifo #(
	parameter int SU_DP = 4
) (
	input  logic CLK,
	input  logic reset,

	input  logic su_dispatch_valid,
	input  lsu_pkg::su_issue_info_t su_dispatch_info,
	output logic su_dispatch_ready,

	input  logic su_fifo_pop,
	output logic su_fifo_empty,
	output lsu_pkg::su_issue_info_t su_issue_info
);

	localparam int AW = $clog2(SU_DP);

	// Pointers carry one extra wrap bit
	logic [AW:0] rd_ptr;
	logic [AW:0] wr_ptr;
	lsu_pkg::su_issue_info_t fifo_mem [SU_DP];
	logic fifo_full;
	logic push;
	logic pop;

	// Same index, different lap means full
	assign su_fifo_empty = (rd_ptr == wr_ptr);
	assign fifo_full = (rd_ptr[AW] != wr_ptr[AW]) && (rd_ptr[AW-1:0] == wr_ptr[AW-1:0]);

	assign su_dispatch_ready = ~fifo_full;
	assign push = su_dispatch_valid & ~fifo_full;
	assign pop = su_fifo_pop & ~su_fifo_empty;

	always_ff @(posedge CLK) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Storage
	always_ff @(posedge CLK) begin
		if (push) begin
			fifo_mem[wr_ptr[AW-1:0]] <= su_dispatch_info;
		end
	end

	// Head store, read combinationally
	assign su_issue_info = fifo_mem[rd_ptr[AW-1:0]];

endmodule

// File: verilog/regfile_wblog.sv
/* One bank of physical registers, no bypass: a write shows the cycle after.
   Register 0 reads zero and is always ready; allocation beats write-back on one index */
module regfile_wblog (
	input  logic CLK,
	input  logic reset,

	// From rename
	input  logic rd_alloc_valid,
	input  lsu_pkg::preg_t rd_alloc_index,

	// From write-back
	input  logic wb_valid,
	input  lsu_pkg::preg_t wb_index,
	input  lsu_pkg::xlen_t wb_data,

	output lsu_pkg::xlen_t regfile_read [lsu_pkg::PREG_NUM],
	output logic [lsu_pkg::PREG_NUM-1:0] wblog
);

	logic wb_write;
	logic alloc_clear;

	// Index 0 never written or cleared
	assign wb_write = wb_valid && (wb_index != '0);
	assign alloc_clear = rd_alloc_valid && (rd_alloc_index != '0);

	// Register values
	// All zero out of reset
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < lsu_pkg::PREG_NUM; i++) begin
				regfile_read[i] <= '0;
			end
		end else if (wb_write) begin
			regfile_read[wb_index] <= wb_data;
		end
	end

	// Write-back log
	// Set means the value is final; cleared on allocation until written back
	always_ff @(posedge CLK) begin
		if (reset) begin
			wblog <= '1;
		end else begin
			if (wb_write) begin
				wblog[wb_index] <= 1'b1;
			end
			// Later assignment, so allocation wins a same-index clash
			if (alloc_clear) begin
				wblog[rd_alloc_index] <= 1'b0;
			end
		end
	end

endmodule

// File: verilog/lsu_issue.sv
/* Loads issue out of order, lowest ready slot first; stores strictly in order once
   commit allows. Output words load only while the consumer is ready */
module lsu_issue #(
	parameter int LU_DP = 8
) (
	input  logic CLK,
	input  logic reset,

	lu_issue_if.issue lu_issue,

	input  logic lu_exe_ready,
	output logic lu_exe_valid,
	output lsu_pkg::lu_exeparam_t lu_exeparam,

	output logic su_fifo_pop,
	input  logic su_fifo_empty,
	input  lsu_pkg::su_issue_info_t su_issue_info,

	input  logic su_exe_ready,
	output logic su_exe_valid,
	output lsu_pkg::su_exeparam_t su_exeparam,

	input  lsu_pkg::xlen_t regfile_read [lsu_pkg::PREG_NUM],
	input  logic [lsu_pkg::PREG_NUM-1:0] wblog,
	input  logic su_ilp_ready
);

	localparam int IDX_W = $clog2(LU_DP);

	// Per-slot load decode
	logic [LU_DP-1:0] lu_fun_lb;
	logic [LU_DP-1:0] lu_fun_lh;
	logic [LU_DP-1:0] lu_fun_lw;
	logic [LU_DP-1:0] lu_fun_ld;
	logic [LU_DP-1:0] lu_is_usi;
	logic [LU_DP-1:0] lu_clear_raw;
	lsu_pkg::preg_t lu_rd0 [LU_DP];
	lsu_pkg::preg_t lu_rs1 [LU_DP];
	lsu_pkg::xlen_t lu_imm [LU_DP];
	lsu_pkg::xlen_t lu_op1 [LU_DP];

	logic [IDX_W-1:0] lu_sel;
	logic lu_any_clear;
	logic lu_valid_dnxt;
	lsu_pkg::lu_exeparam_t lu_exeparam_dnxt;

	generate
		for (genvar g = 0; g < LU_DP; g++) begin : g_lu_slot
			assign lu_rs1[g] = lu_issue.info[g][lsu_pkg::LU_RS1_LSB +: lsu_pkg::PREG_W];
			assign lu_rd0[g] = lu_issue.info[g][lsu_pkg::LU_RD0_LSB +: lsu_pkg::PREG_W];
			assign lu_imm[g] = lu_issue.info[g][lsu_pkg::LU_IMM_LSB +: lsu_pkg::XLEN];

			// Signed and unsigned share a width flag
			assign lu_fun_lb[g] = lu_issue.info[g][lsu_pkg::LU_LB_BIT]
				| lu_issue.info[g][lsu_pkg::LU_LBU_BIT];
			assign lu_fun_lh[g] = lu_issue.info[g][lsu_pkg::LU_LH_BIT]
				| lu_issue.info[g][lsu_pkg::LU_LHU_BIT];
			assign lu_fun_lw[g] = lu_issue.info[g][lsu_pkg::LU_LW_BIT]
				| lu_issue.info[g][lsu_pkg::LU_LWU_BIT];
			assign lu_fun_ld[g] = lu_issue.info[g][lsu_pkg::LU_LD_BIT];
			assign lu_is_usi[g] = lu_issue.info[g][lsu_pkg::LU_LBU_BIT]
				| lu_issue.info[g][lsu_pkg::LU_LHU_BIT]
				| lu_issue.info[g][lsu_pkg::LU_LWU_BIT];

			// Occupied with base register written back
			assign lu_clear_raw[g] = lu_issue.malloc[g] & wblog[lu_rs1[g]];

			// Effective address
			assign lu_op1[g] = regfile_read[lu_rs1[g]] + lu_imm[g];
		end
	endgenerate

	// Lowest ready slot wins
	always_comb begin
		lu_sel = '0;
		for (int i = LU_DP - 1; i >= 0; i--) begin
			if (lu_clear_raw[i]) begin
				lu_sel = IDX_W'(i);
			end
		end
	end

	assign lu_any_clear = |lu_clear_raw;

	// Pack the selected slot
	always_comb begin
		lu_exeparam_dnxt = '0;
		lu_exeparam_dnxt[lsu_pkg::LU_EXE_LB_BIT] = lu_fun_lb[lu_sel];
		lu_exeparam_dnxt[lsu_pkg::LU_EXE_LH_BIT] = lu_fun_lh[lu_sel];
		lu_exeparam_dnxt[lsu_pkg::LU_EXE_LW_BIT] = lu_fun_lw[lu_sel];
		lu_exeparam_dnxt[lsu_pkg::LU_EXE_LD_BIT] = lu_fun_ld[lu_sel];
		lu_exeparam_dnxt[lsu_pkg::LU_EXE_RD0_LSB +: lsu_pkg::PREG_W] = lu_rd0[lu_sel];
		lu_exeparam_dnxt[lsu_pkg::LU_EXE_OP1_LSB +: lsu_pkg::XLEN] = lu_op1[lu_sel];
		lu_exeparam_dnxt[lsu_pkg::LU_EXE_USI_BIT] = lu_is_usi[lu_sel];
	end

	// Hold under back-pressure
	assign lu_valid_dnxt = lu_exe_ready ? lu_any_clear : lu_exe_valid;
	assign lu_issue.pop = lu_exe_ready & lu_any_clear;
	assign lu_issue.pop_index = lu_sel;

	always_ff @(posedge CLK) begin
		if (reset) begin
			lu_exe_valid <= 1'b0;
		end else begin
			lu_exe_valid <= lu_valid_dnxt;
		end
	end

	always_ff @(posedge CLK) begin
		if (lu_exe_ready) begin
			lu_exeparam <= lu_exeparam_dnxt;
		end
	end

	// Store head decode
	lsu_pkg::preg_t su_rs1;
	lsu_pkg::preg_t su_rs2;
	lsu_pkg::xlen_t su_imm;
	logic su_issue_ok;
	logic su_valid_dnxt;
	lsu_pkg::su_exeparam_t su_exeparam_dnxt;

	assign su_rs1 = su_issue_info[lsu_pkg::SU_RS1_LSB +: lsu_pkg::PREG_W];
	assign su_rs2 = su_issue_info[lsu_pkg::SU_RS2_LSB +: lsu_pkg::PREG_W];
	assign su_imm = su_issue_info[lsu_pkg::SU_IMM_LSB +: lsu_pkg::XLEN];

	// Both operands final and commit says no rollback
	assign su_issue_ok = ~su_fifo_empty & wblog[su_rs1] & wblog[su_rs2] & su_ilp_ready;

	always_comb begin
		su_exeparam_dnxt = '0;
		su_exeparam_dnxt[lsu_pkg::SU_EXE_SB_BIT] = su_issue_info[lsu_pkg::SU_SB_BIT];
		su_exeparam_dnxt[lsu_pkg::SU_EXE_SH_BIT] = su_issue_info[lsu_pkg::SU_SH_BIT];
		su_exeparam_dnxt[lsu_pkg::SU_EXE_SW_BIT] = su_issue_info[lsu_pkg::SU_SW_BIT];
		su_exeparam_dnxt[lsu_pkg::SU_EXE_SD_BIT] = su_issue_info[lsu_pkg::SU_SD_BIT];
		su_exeparam_dnxt[lsu_pkg::SU_EXE_OP1_LSB +: lsu_pkg::XLEN] = regfile_read[su_rs1] + su_imm;
		su_exeparam_dnxt[lsu_pkg::SU_EXE_OP2_LSB +: lsu_pkg::XLEN] = regfile_read[su_rs2];
	end

	assign su_valid_dnxt = su_exe_ready ? su_issue_ok : su_exe_valid;
	assign su_fifo_pop = su_exe_ready & su_issue_ok;

	always_ff @(posedge CLK) begin
		if (reset) begin
			su_exe_valid <= 1'b0;
		end else begin
			su_exe_valid <= su_valid_dnxt;
		end
	end

	always_ff @(posedge CLK) begin
		if (su_exe_ready) begin
			su_exeparam <= su_exeparam_dnxt;
		end
	end

endmodule

// File: verilog/lsu_issue_top.sv
/* Load/store issue stage without translation or memory access. LU_DP and SU_DP
   must be powers of two, at least 2; su_ilp_ready comes from commit */
module lsu_issue_top #(
	parameter int LU_DP = 8,
	parameter int SU_DP = 4
) (
	input  logic CLK,
	input  logic reset,

	// Load dispatch
	input  logic lu_dispatch_valid,
	input  lsu_pkg::lu_issue_info_t lu_dispatch_info,
	output logic lu_dispatch_ready,

	// Store dispatch
	input  logic su_dispatch_valid,
	input  lsu_pkg::su_issue_info_t su_dispatch_info,
	output logic su_dispatch_ready,

	// Rename and write-back
	input  logic rd_alloc_valid,
	input  lsu_pkg::preg_t rd_alloc_index,
	input  logic wb_valid,
	input  lsu_pkg::preg_t wb_index,
	input  lsu_pkg::xlen_t wb_data,

	input  logic su_ilp_ready,

	// Execution side
	input  logic lu_exe_ready,
	output logic lu_exe_valid,
	output lsu_pkg::lu_exeparam_t lu_exeparam,
	input  logic su_exe_ready,
	output logic su_exe_valid,
	output lsu_pkg::su_exeparam_t su_exeparam
);

	lu_issue_if #(.LU_DP(LU_DP)) lu_issue ();

	logic su_fifo_pop;
	logic su_fifo_empty;
	lsu_pkg::su_issue_info_t su_issue_info;
	lsu_pkg::xlen_t regfile_read [lsu_pkg::PREG_NUM];
	logic [lsu_pkg::PREG_NUM-1:0] wblog;

	lu_issue_buffer #(.LU_DP(LU_DP)) lu_issue_buffer_i (
		.CLK              (CLK),
		.reset            (reset),
		.lu_dispatch_valid(lu_dispatch_valid),
		.lu_dispatch_info (lu_dispatch_info),
		.lu_dispatch_ready(lu_dispatch_ready),
		.lu_issue         (lu_issue.buffer)
	);

	su_issue_fifo #(.SU_DP(SU_DP)) su_issue_fifo_i (
		.CLK              (CLK),
		.reset            (reset),
		.su_dispatch_valid(su_dispatch_valid),
		.su_dispatch_info (su_dispatch_info),
		.su_dispatch_ready(su_dispatch_ready),
		.su_fifo_pop      (su_fifo_pop),
		.su_fifo_empty    (su_fifo_empty),
		.su_issue_info    (su_issue_info)
	);

	regfile_wblog regfile_wblog_i (
		.CLK           (CLK),
		.reset         (reset),
		.rd_alloc_valid(rd_alloc_valid),
		.rd_alloc_index(rd_alloc_index),
		.wb_valid      (wb_valid),
		.wb_index      (wb_index),
		.wb_data       (wb_data),
		.regfile_read  (regfile_read),
		.wblog         (wblog)
	);

	lsu_issue #(.LU_DP(LU_DP)) lsu_issue_i (
		.CLK          (CLK),
		.reset        (reset),
		.lu_issue     (lu_issue.issue),
		.lu_exe_ready (lu_exe_ready),
		.lu_exe_valid (lu_exe_valid),
		.lu_exeparam  (lu_exeparam),
		.su_fifo_pop  (su_fifo_pop),
		.su_fifo_empty(su_fifo_empty),
		.su_issue_info(su_issue_info),
		.su_exe_ready (su_exe_ready),
		.su_exe_valid (su_exe_valid),
		.su_exeparam  (su_exeparam),
		.regfile_read (regfile_read),
		.wblog        (wblog),
		.su_ilp_ready (su_ilp_ready)
	);

endmodule

// File: verif/tb_clock.sv
/* Free-running testbench clock, starts low */
module tb_clock #(
	parameter int PERIOD = 100
) (
	output logic CLK
);

	initial begin
		CLK = 1'b0;
	end

	// Half period per phase
	always #(PERIOD / 2) CLK = ~CLK;

endmodule

// File: verif/lsu_issue_tb.sv
/* Directed tests of the load/store issue stage. All driving and sampling happens
   on the falling edge; stimulus words are built from the field order MSB first */
module lsu_issue_tb;

	localparam int LU_DP = 8;
	localparam int SU_DP = 4;
	localparam int TIMEOUT = 50;

	// Selectors for the level waits
	localparam int SEL_LU_VALID = 0;
	localparam int SEL_SU_VALID = 1;
	localparam int SEL_LU_READY = 2;
	localparam int SEL_SU_READY = 3;

	logic CLK;
	logic reset;
	logic lu_dispatch_valid;
	lsu_pkg::lu_issue_info_t lu_dispatch_info;
	logic lu_dispatch_ready;
	logic su_dispatch_valid;
	lsu_pkg::su_issue_info_t su_dispatch_info;
	logic su_dispatch_ready;
	logic rd_alloc_valid;
	lsu_pkg::preg_t rd_alloc_index;
	logic wb_valid;
	lsu_pkg::preg_t wb_index;
	lsu_pkg::xlen_t wb_data;
	logic su_ilp_ready;
	logic lu_exe_ready;
	logic lu_exe_valid;
	lsu_pkg::lu_exeparam_t lu_exeparam;
	logic su_exe_ready;
	logic su_exe_valid;
	lsu_pkg::su_exeparam_t su_exeparam;

	// Reference register file
	lsu_pkg::xlen_t ref_val [lsu_pkg::PREG_NUM];
	logic ref_rdy [lsu_pkg::PREG_NUM];
	logic [31:0] lcg_state;

	tb_clock #(.PERIOD(100)) tb_clock_i (.CLK(CLK));

	lsu_issue_top #(.LU_DP(LU_DP), .SU_DP(SU_DP)) lsu_issue_top_i (
		.CLK              (CLK),
		.reset            (reset),
		.lu_dispatch_valid(lu_dispatch_valid),
		.lu_dispatch_info (lu_dispatch_info),
		.lu_dispatch_ready(lu_dispatch_ready),
		.su_dispatch_valid(su_dispatch_valid),
		.su_dispatch_info (su_dispatch_info),
		.su_dispatch_ready(su_dispatch_ready),
		.rd_alloc_valid   (rd_alloc_valid),
		.rd_alloc_index   (rd_alloc_index),
		.wb_valid         (wb_valid),
		.wb_index         (wb_index),
		.wb_data          (wb_data),
		.su_ilp_ready     (su_ilp_ready),
		.lu_exe_ready     (lu_exe_ready),
		.lu_exe_valid     (lu_exe_valid),
		.lu_exeparam      (lu_exeparam),
		.su_exe_ready     (su_exe_ready),
		.su_exe_valid     (su_exe_valid),
		.su_exeparam      (su_exeparam)
	);

	// LCG, numerical recipes constants
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic lsu_pkg::xlen_t rand_xlen();
		return {next_rand(), next_rand()};
	endfunction

	// Kind 0..6 is lb lh lw ld lbu lhu lwu
	function automatic lsu_pkg::lu_issue_info_t load_word(input int kind, input int rd0,
		input int rs1, input lsu_pkg::xlen_t imm);
		logic [6:0] flags;
		flags = 7'b1000000 >> kind;
		return {flags, imm, lsu_pkg::preg_t'(rd0), lsu_pkg::preg_t'(rs1)};
	endfunction

	// Unsigned kinds share the signed width flag
	function automatic lsu_pkg::lu_exeparam_t load_param(input int kind, input int rd0,
		input lsu_pkg::xlen_t addr);
		logic [3:0] width;
		logic usi;
		width = 4'b1000 >> (kind % 4);
		usi = (kind >= 4);
		return {width, lsu_pkg::preg_t'(rd0), addr, usi};
	endfunction

	// Kind 0..3 is sb sh sw sd
	function automatic lsu_pkg::su_issue_info_t store_word(input int kind, input int rs1,
		input int rs2, input lsu_pkg::xlen_t imm);
		logic [3:0] flags;
		flags = 4'b1000 >> kind;
		return {flags, imm, lsu_pkg::preg_t'(rs1), lsu_pkg::preg_t'(rs2)};
	endfunction

	function automatic lsu_pkg::su_exeparam_t store_param(input int kind,
		input lsu_pkg::xlen_t addr, input lsu_pkg::xlen_t data);
		logic [3:0] flags;
		flags = 4'b1000 >> kind;
		return {flags, addr, data};
	endfunction

	function automatic logic sig_level(input int sel);
		case (sel)
			SEL_LU_VALID: return lu_exe_valid;
			SEL_SU_VALID: return su_exe_valid;
			SEL_LU_READY: return lu_dispatch_ready;
			default: return su_dispatch_ready;
		endcase
	endfunction

	task automatic tick();
		@(negedge CLK);
	endtask

	task automatic abort_run();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [lsu_pkg::SU_EXE_W-1:0] got,
		input logic [lsu_pkg::SU_EXE_W-1:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	// Polls once per cycle until the level is high
	task automatic wait_level(input int sel, input string what);
		int n;
		n = 0;
		while (!sig_level(sel)) begin
			if (n == TIMEOUT) begin
				$display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
				abort_run();
			end
			tick();
			n++;
		end
	endtask

	task automatic write_back(input int idx, input lsu_pkg::xlen_t data);
		wb_valid = 1'b1;
		wb_index = lsu_pkg::preg_t'(idx);
		wb_data = data;
		tick();
		wb_valid = 1'b0;
		// Register 0 stays zero
		if (idx != 0) begin
			ref_val[idx] = data;
			ref_rdy[idx] = 1'b1;
		end
	endtask

	task automatic alloc_reg(input int idx);
		rd_alloc_valid = 1'b1;
		rd_alloc_index = lsu_pkg::preg_t'(idx);
		tick();
		rd_alloc_valid = 1'b0;
		if (idx != 0) begin
			ref_rdy[idx] = 1'b0;
		end
	endtask

	task automatic dispatch_load(input lsu_pkg::lu_issue_info_t info);
		wait_level(SEL_LU_READY, "lu_dispatch_ready");
		lu_dispatch_valid = 1'b1;
		lu_dispatch_info = info;
		tick();
		lu_dispatch_valid = 1'b0;
	endtask

	task automatic dispatch_store(input lsu_pkg::su_issue_info_t info);
		wait_level(SEL_SU_READY, "su_dispatch_ready");
		su_dispatch_valid = 1'b1;
		su_dispatch_info = info;
		tick();
		su_dispatch_valid = 1'b0;
	endtask

	task automatic test_reset_state();
		check_value("lu_exe_valid", lu_exe_valid, 1'b0);
		check_value("su_exe_valid", su_exe_valid, 1'b0);
		check_value("lu_dispatch_ready", lu_dispatch_ready, 1'b1);
		check_value("su_dispatch_ready", su_dispatch_ready, 1'b1);
	endtask

	// One load per kind, base register k, so kind 0 uses register 0
	task automatic test_load_kinds();
		lsu_pkg::xlen_t imm;
		for (int k = 0; k < 7; k++) begin
			imm = rand_xlen();
			if (k != 0) begin
				write_back(k, rand_xlen());
			end
			dispatch_load(load_word(k, k + 10, k, imm));
			// Entry visible now, word one edge later
			check_value("lu_exe_valid", lu_exe_valid, 1'b0);
			tick();
			check_value("lu_exe_valid", lu_exe_valid, 1'b1);
			check_value("lu_exeparam", lu_exeparam, load_param(k, k + 10, ref_val[k] + imm));
			tick();
			check_value("lu_exe_valid", lu_exe_valid, 1'b0);
		end
	endtask

	task automatic test_out_of_order();
		lsu_pkg::xlen_t imm_a;
		lsu_pkg::xlen_t imm_b;
		imm_a = rand_xlen();
		imm_b = rand_xlen();
		alloc_reg(20);
		// A waits on register 20, B has a final base
		dispatch_load(load_word(2, 21, 20, imm_a));
		dispatch_load(load_word(3, 22, 5, imm_b));
		wait_level(SEL_LU_VALID, "younger load B");
		check_value("lu_exeparam", lu_exeparam, load_param(3, 22, ref_val[5] + imm_b));
		repeat (4) begin
			tick();
			check_value("lu_exe_valid", lu_exe_valid, 1'b0);
		end
		write_back(20, rand_xlen());
		wait_level(SEL_LU_VALID, "older load A");
		check_value("lu_exeparam", lu_exeparam, load_param(2, 21, ref_val[20] + imm_a));
		tick();
	endtask

	task automatic test_back_pressure();
		lsu_pkg::xlen_t imm;
		lsu_pkg::lu_exeparam_t held;
		lsu_pkg::lu_exeparam_t expq [$];
		int base;
		imm = rand_xlen();
		dispatch_load(load_word(0, 40, 1, imm));
		wait_level(SEL_LU_VALID, "first back-pressure load");
		lu_exe_ready = 1'b0;
		held = load_param(0, 40, ref_val[1] + imm);
		check_value("lu_exeparam", lu_exeparam, held);
		// Fill every slot while the word is held
		for (int i = 0; i < LU_DP; i++) begin
			base = 1 + i % 6;
			imm = rand_xlen();
			expq.push_back(load_param(i % 7, 41 + i, ref_val[base] + imm));
			dispatch_load(load_word(i % 7, 41 + i, base, imm));
			check_value("lu_exe_valid", lu_exe_valid, 1'b1);
			check_value("lu_exeparam", lu_exeparam, held);
		end
		check_value("lu_dispatch_ready", lu_dispatch_ready, 1'b0);
		tick();
		check_value("lu_exeparam", lu_exeparam, held);
		check_value("lu_dispatch_ready", lu_dispatch_ready, 1'b0);
		// Drain back to back, slot order equals dispatch order here
		lu_exe_ready = 1'b1;
		for (int i = 0; i < LU_DP; i++) begin
			tick();
			check_value("lu_exe_valid", lu_exe_valid, 1'b1);
			check_value("lu_exeparam", lu_exeparam, expq[i]);
		end
		tick();
		check_value("lu_exe_valid", lu_exe_valid, 1'b0);
	endtask

	task automatic test_stores();
		lsu_pkg::xlen_t imm0;
		lsu_pkg::xlen_t imm1;
		lsu_pkg::su_exeparam_t exp0;
		lsu_pkg::su_exeparam_t exp1;
		imm0 = rand_xlen();
		imm1 = rand_xlen();
		alloc_reg(30);
		// Older sw waits on data register 30, younger sd is ready
		dispatch_store(store_word(2, 1, 30, imm0));
		dispatch_store(store_word(3, 2, 3, imm1));
		su_ilp_ready = 1'b1;
		repeat (4) begin
			tick();
			check_value("su_exe_valid", su_exe_valid, ref_rdy[30]);
		end
		// Commit blocks once data is final
		su_ilp_ready = 1'b0;
		write_back(30, rand_xlen());
		repeat (4) begin
			tick();
			check_value("su_exe_valid", su_exe_valid, 1'b0);
		end
		exp0 = store_param(2, ref_val[1] + imm0, ref_val[30]);
		exp1 = store_param(3, ref_val[2] + imm1, ref_val[3]);
		su_ilp_ready = 1'b1;
		wait_level(SEL_SU_VALID, "older store");
		check_value("su_exeparam", su_exeparam, exp0);
		su_exe_ready = 1'b0;
		repeat (3) begin
			tick();
			check_value("su_exe_valid", su_exe_valid, 1'b1);
			check_value("su_exeparam", su_exeparam, exp0);
		end
		su_exe_ready = 1'b1;
		tick();
		wait_level(SEL_SU_VALID, "younger store");
		check_value("su_exeparam", su_exeparam, exp1);
		tick();
		check_value("su_exe_valid", su_exe_valid, 1'b0);
	endtask

	initial begin
		lcg_state = 32'hde95a809;
		reset = 1'b1;
		lu_dispatch_valid = 1'b0;
		lu_dispatch_info = '0;
		su_dispatch_valid = 1'b0;
		su_dispatch_info = '0;
		rd_alloc_valid = 1'b0;
		rd_alloc_index = '0;
		wb_valid = 1'b0;
		wb_index = '0;
		wb_data = '0;
		su_ilp_ready = 1'b0;
		lu_exe_ready = 1'b1;
		su_exe_ready = 1'b1;
		// Matches the register file out of reset
		for (int i = 0; i < lsu_pkg::PREG_NUM; i++) begin
			ref_val[i] = '0;
			ref_rdy[i] = 1'b1;
		end
		repeat (8) tick();
		reset = 1'b0;
		tick();
		test_reset_state();
		test_load_kinds();
		test_out_of_order();
		test_back_pressure();
		test_stores();
		$display("Everything OK");
		$finish;
	end

endmodule

// File: all.f
verilog/lsu_pkg.sv
verilog/lu_issue_if.sv
verilog/lu_issue_buffer.sv
verilog/su_issue_fifo.sv
verilog/regfile_wblog.sv
verilog/lsu_issue.sv
verilog/lsu_issue_top.sv
verif/tb_clock.sv
verif/lsu_issue_tb.sv
